/* design/audio_macros.svh */
`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

// sample memory word address bits
`define AUDIO_ADDR_W 16

// one volume field, scale 0..127 in 1/128 steps
`define AUDIO_VOL_W 7

// frame counter bits, one mix frame is 2^8 clocks
`define AUDIO_FRAME_W 8

`endif

/* design/audio_pkg.sv */
`default_nettype none

`include "audio_macros.svh"

package audio_pkg;

    typedef logic [15:0] word_t;                    // two samples, high byte plays first
    typedef logic [`AUDIO_ADDR_W-1:0] addr_t;      // sample memory word address
    typedef logic signed [7:0] sample_t;           // signed 8-bit pcm
    typedef logic [`AUDIO_VOL_W-1:0] vol_t;        // unsigned, 127 is near unity

    typedef enum logic {
        FETCH_IDLE = 1'b0,                          // spare word full or voice off
        FETCH_WAIT = 1'b1                           // request out, waiting for ack
    } fetch_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,                           // no grant
        ARB_BUSY0 = 2'd1,                           // port granted to voice 0
        ARB_BUSY1 = 2'd2                            // port granted to voice 1
    } arb_state_e;

endpackage

`default_nettype wire

/* design/audio_fetch_if.sv */
`default_nettype none

interface audio_fetch_if;
    logic               fetch_req;      // held high until fetch_ack
    audio_pkg::addr_t   fetch_addr;     // stable while fetch_req is high
    logic               fetch_ack;      // single cycle, word valid with it
    audio_pkg::word_t   fetch_word;     // returned sample word

    modport voice (
        output fetch_req, fetch_addr,
        input  fetch_ack, fetch_word
    );

    modport arbiter (
        input  fetch_req, fetch_addr,
        output fetch_ack, fetch_word
    );
endinterface

`default_nettype wire

/* design/audio_voice.sv */
`default_nettype none

module audio_voice (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               enable_i,   // low parks the voice at start_i
    input  wire logic               frame_i,    // frame tick from the mixer
    input  wire audio_pkg::addr_t   start_i,
    input  wire logic [15:0]        len_i,      // loop length in words
    input  wire logic [15:0]        period_i,   // each byte lasts period_i+1 frames
    audio_fetch_if.voice            fetch,
    output audio_pkg::sample_t      sample_o,
    output logic                    reload_o    // one cycle when the walk wraps
);
    audio_pkg::fetch_state_e fetch_state;
    audio_pkg::word_t        cur_word;          // word being played
    audio_pkg::word_t        spare_word;        // prefetched next word
    audio_pkg::addr_t        addr;              // address of the word to fetch next
    logic                    cur_valid;
    logic                    spare_valid;
    logic                    low_byte;          // next byte step plays bits 7:0
    logic                    discard;           // disabled while a fetch was in flight
    logic [15:0]             len_cnt;           // words left from addr to loop end
    logic [15:0]             period_cnt;
    logic                    byte_step;
    logic                    word_done;
    logic                    move;
    logic                    issue;
    logic                    take_word;

    always_comb begin
        byte_step = frame_i && (period_cnt == 16'd0) && cur_valid;  // no word, no advance
        word_done = byte_step && low_byte;                          // second byte of the word
        move      = spare_valid && (!cur_valid || word_done);       // spare becomes current
        issue     = (fetch_state == audio_pkg::FETCH_IDLE) && enable_i && !spare_valid;
        take_word = (fetch_state == audio_pkg::FETCH_WAIT) && fetch.fetch_ack
                    && enable_i && !discard;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_state     <= audio_pkg::FETCH_IDLE;
            fetch.fetch_req <= 1'b0;
            discard         <= 1'b0;
            addr            <= '0;
            len_cnt         <= '0;
            period_cnt      <= '0;
            cur_valid       <= 1'b0;
            spare_valid     <= 1'b0;
            low_byte        <= 1'b0;
            sample_o        <= '0;
            reload_o        <= 1'b0;
        end else begin
            reload_o <= 1'b0;
            if (!enable_i) begin
                addr        <= start_i;         // restart the walk on enable
                len_cnt     <= len_i;
                period_cnt  <= '0;              // first byte at the first tick once ready
                cur_valid   <= 1'b0;
                spare_valid <= 1'b0;
                low_byte    <= 1'b0;
                sample_o    <= '0;
            end else begin
                if (frame_i) begin
                    period_cnt <= (period_cnt == 16'd0) ? period_i : period_cnt - 16'd1;
                end
                if (byte_step) begin
                    sample_o <= low_byte ? cur_word[7:0] : cur_word[15:8];
                    low_byte <= !low_byte;
                end
                if (word_done) cur_valid <= 1'b0;
                if (move) begin
                    cur_valid   <= 1'b1;
                    spare_valid <= 1'b0;
                    if (len_cnt <= 16'd1) begin     // last word of the loop went out
                        addr     <= start_i;
                        len_cnt  <= len_i;
                        reload_o <= 1'b1;
                    end else begin
                        addr    <= addr + 1'b1;
                        len_cnt <= len_cnt - 16'd1;
                    end
                end
                if (take_word) spare_valid <= 1'b1;
            end

            case (fetch_state)
                audio_pkg::FETCH_IDLE: begin
                    if (issue) begin
                        fetch.fetch_req <= 1'b1;
                        fetch_state     <= audio_pkg::FETCH_WAIT;
                    end
                end
                audio_pkg::FETCH_WAIT: begin
                    if (!enable_i) discard <= 1'b1;   // word arrives stale, drop it
                    if (fetch.fetch_ack) begin
                        fetch.fetch_req <= 1'b0;      // low the cycle after ack
                        discard         <= 1'b0;
                        fetch_state     <= audio_pkg::FETCH_IDLE;
                    end
                end
                default: fetch_state <= audio_pkg::FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) fetch.fetch_addr <= addr;        // held for the whole request
        if (take_word) spare_word <= fetch.fetch_word;
        if (move) cur_word <= spare_word;
    end

endmodule

`default_nettype wire

/* design/audio_dma_arb.sv */
`default_nettype none

module audio_dma_arb (
    input  wire logic               clk,
    input  wire logic               reset_i,
    audio_fetch_if.arbiter          voice0,
    audio_fetch_if.arbiter          voice1,
    output logic                    fetch_o,    // held until ack_i
    output audio_pkg::addr_t        addr_o,
    input  wire logic               ack_i,      // one cycle, word_i valid
    input  wire audio_pkg::word_t   word_i
);
    audio_pkg::arb_state_e state;
    logic                  last1;               // voice 1 had the last grant

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= audio_pkg::ARB_IDLE;
            last1 <= 1'b0;
        end else begin
            case (state)
                audio_pkg::ARB_IDLE: begin
                    if (voice0.fetch_req && (!voice1.fetch_req || last1)) begin
                        state <= audio_pkg::ARB_BUSY0;
                    end else if (voice1.fetch_req) begin
                        state <= audio_pkg::ARB_BUSY1;
                    end
                end
                audio_pkg::ARB_BUSY0: begin
                    if (ack_i) begin
                        state <= audio_pkg::ARB_IDLE;   // voice drops req this edge too
                        last1 <= 1'b0;
                    end
                end
                audio_pkg::ARB_BUSY1: begin
                    if (ack_i) begin
                        state <= audio_pkg::ARB_IDLE;
                        last1 <= 1'b1;
                    end
                end
                default: state <= audio_pkg::ARB_IDLE;
            endcase
        end
    end

    always_comb begin
        fetch_o           = (state != audio_pkg::ARB_IDLE);
        addr_o            = (state == audio_pkg::ARB_BUSY1) ? voice1.fetch_addr
                                                            : voice0.fetch_addr;
        voice0.fetch_ack  = ack_i && (state == audio_pkg::ARB_BUSY0);    // same-cycle return
        voice1.fetch_ack  = ack_i && (state == audio_pkg::ARB_BUSY1);
        voice0.fetch_word = (state == audio_pkg::ARB_BUSY0) ? word_i : '0;
        voice1.fetch_word = (state == audio_pkg::ARB_BUSY1) ? word_i : '0;
    end

endmodule

`default_nettype wire

/* design/audio_dac.sv */
`default_nettype none

module audio_dac #(
    parameter int WIDTH = 8
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               clear_i,    // restart the accumulator, exact count per frame
    input  wire logic [WIDTH-1:0]   value_i,    // unsigned level
    output logic                    pdm_o
);
    logic [WIDTH-1:0] acc;
    logic [WIDTH:0]   sum;

    always_comb begin
        sum   = {1'b0, acc} + {1'b0, value_i};
        pdm_o = sum[WIDTH];                     // carry out is the pulse
    end

    // over 2^WIDTH cycles from a clear, carries add up to value_i exactly
    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc <= '0;
        end else if (clear_i) begin
            acc <= '0;
        end else begin
            acc <= sum[WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

/* design/audio_mixer.sv */
`default_nettype none

`include "audio_macros.svh"

module audio_mixer (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   enable_i,
    input  wire audio_pkg::sample_t     sample0_i,
    input  wire audio_pkg::sample_t     sample1_i,
    input  wire audio_pkg::vol_t        vol0_l_i,
    input  wire audio_pkg::vol_t        vol0_r_i,
    input  wire audio_pkg::vol_t        vol1_l_i,
    input  wire audio_pkg::vol_t        vol1_r_i,
    output logic                        frame_o,    // one cycle every 2^AUDIO_FRAME_W clocks
    output logic                        pdm_l_o,
    output logic                        pdm_r_o
);
    logic [`AUDIO_FRAME_W-1:0] frame_cnt;
    logic [7:0]                mix_l;               // latched unsigned level, left
    logic [7:0]                mix_r;
    logic [7:0]                mix_l_next;
    logic [7:0]                mix_r_next;

    // scale, sum, >>>7, clamp, then flip the sign bit for the DAC
    function automatic logic [7:0] mix_side(
        input audio_pkg::sample_t s0,
        input audio_pkg::sample_t s1,
        input audio_pkg::vol_t    v0,
        input audio_pkg::vol_t    v1
    );
        logic signed [15:0] p0;
        logic signed [15:0] p1;
        logic signed [16:0] sum;
        logic signed [16:0] shifted;
        logic signed [7:0]  clamped;
        p0      = s0 * $signed({1'b0, v0});     // volume is zero-extended
        p1      = s1 * $signed({1'b0, v1});
        sum     = p0 + p1;
        shifted = sum >>> 7;
        if (shifted > 17'sd127) begin
            clamped = 8'sd127;
        end else if (shifted < -17'sd128) begin
            clamped = -8'sd128;
        end else begin
            clamped = shifted[7:0];
        end
        return {~clamped[7], clamped[6:0]};     // offset binary, 0x80 is silence
    endfunction

    always_comb begin
        frame_o    = (frame_cnt == '1);          // wrap cycle is the frame tick
        mix_l_next = mix_side(sample0_i, sample1_i, vol0_l_i, vol1_l_i);
        mix_r_next = mix_side(sample0_i, sample1_i, vol0_r_i, vol1_r_i);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frame_cnt <= '0;
            mix_l     <= '0;
            mix_r     <= '0;
        end else begin
            frame_cnt <= frame_cnt + 1'b1;
            if (frame_o) begin                  // samples seen here are pre-step values
                mix_l <= enable_i ? mix_l_next : 8'd0;
                mix_r <= enable_i ? mix_r_next : 8'd0;
            end
        end
    end

    // both DACs restart with the tick, so each frame plays one latched level
    audio_dac #(.WIDTH(8)) dac_l (
        .clk     (clk),
        .reset_i (reset_i),
        .clear_i (frame_o),
        .value_i (mix_l),
        .pdm_o   (pdm_l_o)
    );

    audio_dac #(.WIDTH(8)) dac_r (
        .clk     (clk),
        .reset_i (reset_i),
        .clear_i (frame_o),
        .value_i (mix_r),
        .pdm_o   (pdm_r_o)
    );

endmodule

`default_nettype wire

/* design/audio_mixer_top.sv */
`default_nettype none

module audio_mixer_top (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               enable_i,
    input  wire audio_pkg::addr_t   ch0_start_i,
    input  wire logic [15:0]        ch0_len_i,      // words
    input  wire logic [15:0]        ch0_period_i,   // frames per byte minus one
    input  wire audio_pkg::vol_t    ch0_vol_l_i,
    input  wire audio_pkg::vol_t    ch0_vol_r_i,
    output logic                    ch0_reload_o,
    input  wire audio_pkg::addr_t   ch1_start_i,
    input  wire logic [15:0]        ch1_len_i,
    input  wire logic [15:0]        ch1_period_i,
    input  wire audio_pkg::vol_t    ch1_vol_l_i,
    input  wire audio_pkg::vol_t    ch1_vol_r_i,
    output logic                    ch1_reload_o,
    output logic                    fetch_o,        // shared sample memory port
    output audio_pkg::addr_t        addr_o,
    input  wire logic               ack_i,
    input  wire audio_pkg::word_t   word_i,
    output logic                    frame_o,
    output logic                    pdm_l_o,
    output logic                    pdm_r_o
);
    audio_pkg::sample_t sample0;
    audio_pkg::sample_t sample1;

    audio_fetch_if fetch0 ();
    audio_fetch_if fetch1 ();

    audio_voice voice0 (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i), .frame_i(frame_o),
        .start_i(ch0_start_i), .len_i(ch0_len_i), .period_i(ch0_period_i),
        .fetch(fetch0), .sample_o(sample0), .reload_o(ch0_reload_o)
    );

    audio_voice voice1 (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i), .frame_i(frame_o),
        .start_i(ch1_start_i), .len_i(ch1_len_i), .period_i(ch1_period_i),
        .fetch(fetch1), .sample_o(sample1), .reload_o(ch1_reload_o)
    );

    audio_dma_arb dma_arb (
        .clk(clk), .reset_i(reset_i), .voice0(fetch0), .voice1(fetch1),
        .fetch_o(fetch_o), .addr_o(addr_o), .ack_i(ack_i), .word_i(word_i)
    );

    audio_mixer mixer (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i),
        .sample0_i(sample0), .sample1_i(sample1),
        .vol0_l_i(ch0_vol_l_i), .vol0_r_i(ch0_vol_r_i),
        .vol1_l_i(ch1_vol_l_i), .vol1_r_i(ch1_vol_r_i),
        .frame_o(frame_o), .pdm_l_o(pdm_l_o), .pdm_r_o(pdm_r_o)
    );

endmodule

`default_nettype wire

/* dv/audio_ref.svh */
// memory contents as a hash of the whole word address
function automatic logic [15:0] mem_word(input logic [15:0] a);
    logic [15:0] h;
    h = (a * 16'd40503) ^ (a >> 7) ^ 16'h3c5a;
    if (a[15]) begin                                // upper half holds full-scale bytes only
        return {(h[3] ? 8'h80 : 8'h7f), (h[9] ? 8'h80 : 8'h7f)};
    end
    return h;
endfunction

// expected DAC level for one side from the mix rule
function automatic int mix_level(
    input logic signed [7:0] s0,
    input logic signed [7:0] s1,
    input logic [6:0]        v0,
    input logic [6:0]        v1
);
    int sum;
    sum = int'(s0) * int'({25'd0, v0}) + int'(s1) * int'({25'd0, v1});
    sum = sum >>> 7;                                // arithmetic shift since int is signed
    if (sum > 127) sum = 127;
    if (sum < -128) sum = -128;
    return sum + 128;                               // flipping the sign bit is the same as +128
endfunction

/* dv/audio_checker.sv */
`default_nettype none

module audio_checker (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           enable_i,
    input  wire logic           frame_i,
    input  wire logic           pdm_l_i,
    input  wire logic           pdm_r_i,
    input  wire logic           step0_i,        // voice byte step for locking and timing checks
    input  wire logic           step1_i,
    input  wire logic           reload0_i,
    input  wire logic           reload1_i,
    input  wire logic [15:0]    start0_i,
    input  wire logic [15:0]    len0_i,
    input  wire logic [15:0]    period0_i,
    input  wire logic [15:0]    start1_i,
    input  wire logic [15:0]    len1_i,
    input  wire logic [15:0]    period1_i,
    input  wire logic [6:0]     vol0_l_i,
    input  wire logic [6:0]     vol0_r_i,
    input  wire logic [6:0]     vol1_l_i,
    input  wire logic [6:0]     vol1_r_i,
    output int                  errors_o,
    output int                  frames_o,
    output int                  checks_o,
    output int                  reloads_o,
    output int                  sat_o           // frames expected at 0 or 255
);
`include "audio_ref.svh"

    int                 cnt_l;                  // pulses since the last tick
    int                 cnt_r;
    int                 exp_l;                  // level latched at the last tick
    int                 exp_r;
    logic               locked [2];
    int                 idx [2];                // byte index in the looped stream
    int                 wait_f [2];             // frames left before the next step
    logic signed [7:0]  smp [2];                // model of sample_o
    logic               rl_exp [2];             // reload pulse due in this cycle

    function automatic logic signed [7:0] byte_at(
        input logic [15:0] start,
        input logic [15:0] len,
        input int          n
    );
        logic [15:0] w;
        int          k;
        k = (n / 2) % int'(len);
        w = mem_word(start + k[15:0]);
        return (n % 2) ? w[7:0] : w[15:8];      // high byte first
    endfunction

    always @(posedge clk) begin
        int          l;
        int          r;
        logic        step;
        logic        due;
        logic        rl;
        logic [15:0] st;
        logic [15:0] ln;
        logic [15:0] pd;
        if (reset_i) begin
            cnt_l = 0;
            cnt_r = 0;
            exp_l = 0;                          // mix resets to 0
            exp_r = 0;
            errors_o = 0;
            frames_o = 0;
            checks_o = 0;
            reloads_o = 0;
            sat_o = 0;
            for (int v = 0; v < 2; v++) begin
                locked[v] = 1'b0;
                idx[v] = 0;
                wait_f[v] = 0;
                smp[v] = '0;
                rl_exp[v] = 1'b0;
            end
        end else begin
            if (reload0_i) reloads_o++;
            for (int v = 0; v < 2; v++) begin
                rl = v ? reload1_i : reload0_i;
                if (locked[v] && rl != rl_exp[v]) begin
                    errors_o++;
                    $display("Mismatch at %0t: ch%0d_reload_o expected %0b actual %0b",
                             $time, v, rl_exp[v], rl);
                end
                rl_exp[v] = 1'b0;
            end
            l = cnt_l + int'(pdm_l_i);          // the tick cycle still plays the old level
            r = cnt_r + int'(pdm_r_i);
            if (frame_i) begin
                frames_o++;
                checks_o += 2;
                if (l != exp_l) begin
                    errors_o++;
                    $display("Mismatch at %0t: pdm_l_o count expected %0d actual %0d",
                             $time, exp_l, l);
                end
                if (r != exp_r) begin
                    errors_o++;
                    $display("Mismatch at %0t: pdm_r_o count expected %0d actual %0d",
                             $time, exp_r, r);
                end
                l = 0;
                r = 0;
                // latch from pre-step samples for play in the next frame
                exp_l = enable_i ? mix_level(smp[0], smp[1], vol0_l_i, vol1_l_i) : 0;
                exp_r = enable_i ? mix_level(smp[0], smp[1], vol0_r_i, vol1_r_i) : 0;
                if (enable_i && (exp_l == 0 || exp_l == 255 || exp_r == 0 || exp_r == 255)) begin
                    sat_o++;
                end
                for (int v = 0; v < 2 && enable_i; v++) begin
                    step = v ? step1_i : step0_i;
                    st = v ? start1_i : start0_i;
                    ln = v ? len1_i : len0_i;
                    pd = v ? period1_i : period0_i;
                    if (!locked[v]) begin
                        if (step) begin         // first byte of the stream
                            locked[v] = 1'b1;
                            idx[v] = 0;
                            smp[v] = byte_at(st, ln, 0);
                            wait_f[v] = int'(pd);
                        end
                    end else begin
                        due = (wait_f[v] == 0);
                        if (step != due) begin
                            errors_o++;
                            $display("Mismatch at %0t: voice%0d byte step expected %0b actual %0b",
                                     $time, v, due, step);
                        end
                        if (due) begin
                            idx[v]++;
                            smp[v] = byte_at(st, ln, idx[v]);
                            wait_f[v] = int'(pd);
                            // moving in the last word of the loop pulses reload
                            if ((idx[v] % 2 == 1)
                                    && (((idx[v] + 1) / 2) % int'(ln) == int'(ln) - 1)) begin
                                rl_exp[v] = 1'b1;
                            end
                        end else begin
                            wait_f[v]--;
                        end
                    end
                end
            end
            cnt_l = l;
            cnt_r = r;
            if (!enable_i) begin                // disabled voice is parked and silent
                for (int v = 0; v < 2; v++) begin
                    locked[v] = 1'b0;
                    smp[v] = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/audio_props.sv */
`default_nettype none

module audio_props (
    input wire logic        clk,
    input wire logic        reset_i,
    input wire logic        fetch_o,
    input wire logic [15:0] addr_o,
    input wire logic        ack_i,
    input wire logic        frame_o,
    input wire logic        ch0_reload_o,
    input wire logic        ch1_reload_o
);
    int         fails = 0;                      // assertion failures so far
    logic [8:0] since;                          // cycles since the last frame strobe

    always @(posedge clk) begin
        if (reset_i) since <= '0;
        else since <= frame_o ? 9'd0 : since + 9'd1;
    end

    assert property (@(posedge clk) disable iff (reset_i)
        fetch_o && !ack_i |=> fetch_o && $stable(addr_o))
        else begin fails++; $error("fetch dropped or address moved before ack"); end

    assert property (@(posedge clk) disable iff (reset_i) frame_o == (since == 9'd255))
        else begin fails++; $error("frame strobe not on a 256 cycle grid"); end

    assert property (@(posedge clk) disable iff (reset_i) ch0_reload_o |=> !ch0_reload_o)
        else begin fails++; $error("ch0 reload longer than one cycle"); end

    assert property (@(posedge clk) disable iff (reset_i) ch1_reload_o |=> !ch1_reload_o)
        else begin fails++; $error("ch1 reload longer than one cycle"); end

endmodule

bind audio_mixer_top audio_props props (
    .clk(clk), .reset_i(reset_i), .fetch_o(fetch_o), .addr_o(addr_o), .ack_i(ack_i),
    .frame_o(frame_o), .ch0_reload_o(ch0_reload_o), .ch1_reload_o(ch1_reload_o)
);

`default_nettype wire

/* dv/audio_tb.sv */
`default_nettype none

module audio_tb;
`include "audio_ref.svh"

    logic               clk;
    logic               reset_i;
    logic               enable_i;
    audio_pkg::addr_t   ch0_start_i;
    logic [15:0]        ch0_len_i;
    logic [15:0]        ch0_period_i;
    audio_pkg::vol_t    ch0_vol_l_i;
    audio_pkg::vol_t    ch0_vol_r_i;
    audio_pkg::addr_t   ch1_start_i;
    logic [15:0]        ch1_len_i;
    logic [15:0]        ch1_period_i;
    audio_pkg::vol_t    ch1_vol_l_i;
    audio_pkg::vol_t    ch1_vol_r_i;
    logic               ack_i = 1'b0;
    audio_pkg::word_t   word_i = '0;
    wire logic          ch0_reload_o;
    wire logic          ch1_reload_o;
    wire logic          fetch_o;
    audio_pkg::addr_t   addr_o;
    wire logic          frame_o;
    wire logic          pdm_l_o;
    wire logic          pdm_r_o;
    int                 errors;
    int                 frames;
    int                 checks;
    int                 reloads;
    int                 sats;
    integer             seed = 32'hd26c;
    int                 fetch_cnt = 0;      // words served by the memory model
    logic               pending = 1'b0;
    int                 lat = 0;
    int                 passed = 0;
    int                 failed = 0;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // sample memory answering after 1..16 cycles
    always @(posedge clk) begin
        ack_i <= 1'b0;
        if (reset_i) begin
            pending <= 1'b0;
        end else if (pending) begin
            if (lat == 0) begin
                ack_i <= 1'b1;
                word_i <= mem_word(addr_o);
                pending <= 1'b0;
                fetch_cnt <= fetch_cnt + 1;
            end else begin
                lat <= lat - 1;
            end
        end else if (fetch_o && !ack_i) begin  // no new request in the ack cycle
            pending <= 1'b1;
            lat <= int'($unsigned($random(seed)) % 16);
        end
    end

    audio_mixer_top uut (.*);

    audio_checker chk (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i), .frame_i(frame_o),
        .pdm_l_i(pdm_l_o), .pdm_r_i(pdm_r_o),
        .step0_i(uut.voice0.byte_step), .step1_i(uut.voice1.byte_step),
        .reload0_i(ch0_reload_o), .reload1_i(ch1_reload_o),
        .start0_i(ch0_start_i), .len0_i(ch0_len_i), .period0_i(ch0_period_i),
        .start1_i(ch1_start_i), .len1_i(ch1_len_i), .period1_i(ch1_period_i),
        .vol0_l_i(ch0_vol_l_i), .vol0_r_i(ch0_vol_r_i),
        .vol1_l_i(ch1_vol_l_i), .vol1_r_i(ch1_vol_r_i),
        .errors_o(errors), .frames_o(frames), .checks_o(checks),
        .reloads_o(reloads), .sat_o(sats)
    );

    function automatic int total_errors();
        return errors + uut.props.fails;
    endfunction

    task automatic run_frames(input int n);
        int target;
        int cyc;
        target = frames + n;
        cyc = 0;
        while (frames < target && cyc < n * 256 + 512) begin
            @(negedge clk);                     // read checker counts away from the edge
            cyc++;
        end
        if (frames < target) begin
            $display("timeout: frame strobe stopped after %0d cycles", cyc);
            $display("** FAIL **");
            $finish;
        end
    endtask

    task automatic end_test(input string name, input int err_before, input bit ok);
        int e;
        e = total_errors() - err_before;
        if (ok && e == 0) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: failed, %0d errors, extra check %0s", name, e, ok ? "ok" : "bad");
        end
    endtask

    task automatic set_voices(input logic [15:0] s0, input logic [15:0] l0,
                              input logic [15:0] p0, input logic [15:0] s1,
                              input logic [15:0] l1, input logic [15:0] p1);
        @(posedge clk);
        enable_i <= 1'b0;                       // voice parameters change only while parked
        ch0_start_i <= s0;
        ch0_len_i <= l0;
        ch0_period_i <= p0;
        ch1_start_i <= s1;
        ch1_len_i <= l1;
        ch1_period_i <= p1;
    endtask

    task automatic set_vols(input logic [6:0] l0, input logic [6:0] r0,
                            input logic [6:0] l1, input logic [6:0] r1);
        @(posedge clk);
        ch0_vol_l_i <= l0;
        ch0_vol_r_i <= r0;
        ch1_vol_l_i <= l1;
        ch1_vol_r_i <= r1;
    endtask

    task automatic set_enable(input logic e);
        @(posedge clk);
        enable_i <= e;
    endtask

    initial begin
        int e0;
        int r0;
        int f0;
        int s0;
        reset_i = 1'b1;
        enable_i = 1'b0;
        ch0_start_i = '0;
        ch0_len_i = 16'd1;
        ch0_period_i = '0;
        ch0_vol_l_i = '0;
        ch0_vol_r_i = '0;
        ch1_start_i = '0;
        ch1_len_i = 16'd1;
        ch1_period_i = '0;
        ch1_vol_l_i = '0;
        ch1_vol_r_i = '0;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        e0 = total_errors();                    // disabled output with no fetch
        run_frames(3);
        end_test("disabled_output", e0, fetch_cnt == 0);

        e0 = total_errors();                    // voice 0 alone on the left
        set_voices(16'h0010, 16'd4, 16'd0, 16'h0100, 16'd2, 16'd0);
        set_vols(7'd127, 7'd0, 7'd0, 7'd0);
        set_enable(1'b1);
        run_frames(20);
        end_test("single_voice", e0, 1'b1);

        e0 = total_errors();                    // 3 frames per byte and 6 bytes per loop
        set_voices(16'h0040, 16'd3, 16'd2, 16'h0050, 16'd3, 16'd2);
        set_vols(7'd100, 7'd30, 7'd60, 7'd90);
        r0 = reloads;
        set_enable(1'b1);
        run_frames(72);
        end_test("period_loop", e0, (reloads - r0) >= 3 && (reloads - r0) <= 5);

        e0 = total_errors();                    // full-scale data into the clamp
        set_voices(16'h8020, 16'd4, 16'd0, 16'h8020, 16'd4, 16'd0);
        set_vols(7'd127, 7'd127, 7'd127, 7'd127);
        s0 = sats;
        set_enable(1'b1);
        run_frames(32);
        end_test("saturation", e0, sats > s0);

        e0 = total_errors();                    // both voices share the port
        set_voices(16'h0200, 16'd5, 16'd0, 16'h0300, 16'd7, 16'd1);
        set_vols(7'd64, 7'd20, 7'd50, 7'd110);
        set_enable(1'b1);
        run_frames(40);
        end_test("arbitration", e0, 1'b1);

        e0 = total_errors();                    // park mid stream and restart
        run_frames(5);
        set_enable(1'b0);
        run_frames(3);
        f0 = fetch_cnt;
        set_enable(1'b1);
        run_frames(20);
        end_test("disable_reenable", e0, fetch_cnt > f0);

        $display("tests passed %0d failed %0d, frame checks %0d, errors %0d",
                 passed, failed, checks, total_errors());
        if (failed == 0 && total_errors() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* audio_mixer.f */
+incdir+design
+incdir+dv
design/audio_pkg.sv
design/audio_fetch_if.sv
design/audio_voice.sv
design/audio_dma_arb.sv
design/audio_dac.sv
design/audio_mixer.sv
design/audio_mixer_top.sv
dv/audio_checker.sv
dv/audio_props.sv
dv/audio_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the audio mixer testbench with Verilator
set -u
cd "$(dirname "$0")"

if ! verilator --binary --timing --assert -Wno-fatal -f audio_mixer.f \
        --top-module audio_tb -o audio_sim; then
    echo "build failed"
    exit 1
fi

out="$(./obj_dir/audio_sim)"
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '** PASS **' <<< "$out"; then
    exit 0
fi
exit 1
